/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = procTb
FILELIST = proc.f
BUILD    = obj_dir
LOG      = sim.log
FAILMSG  = FAIL: see errors above
PASSMSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)

run: compile
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/decode.sv */
`default_nettype none

module decode (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [procPkg::dataWidth-1:0]     instrD,
	input  logic [procPkg::dataWidth-1:0]     pcPlus2D,
	input  logic                              stall,
	input  logic                              wbEn,
	input  logic [procPkg::regSelWidth-1:0]   wbSel,
	input  logic [procPkg::dataWidth-1:0]     wbData,
	output logic [procPkg::regSelWidth-1:0]   rs1,
	output logic [procPkg::regSelWidth-1:0]   rs2,
	output logic                              uses1,
	output logic                              uses2,
	output logic                              flush,
	output logic [procPkg::dataWidth-1:0]     targetPc,
	output logic                              halting,
	output logic [procPkg::dataWidth-1:0]     rdData1X,
	output logic [procPkg::dataWidth-1:0]     rdData2X,
	output logic [procPkg::dataWidth-1:0]     immX,
	output logic [1:0]                        aluOpX,
	output logic                              aluSrcX,
	output logic                              memReadX,
	output logic                              memWriteX,
	output logic                              regWriteX,
	output logic                              memToRegX,
	output logic                              linkX,
	output logic [procPkg::regSelWidth-1:0]   destX,
	output logic [procPkg::dataWidth-1:0]     pcPlus2X,
	output logic                              haltX,
	output logic                              illegalX
);
	import procPkg::*;

	instrWord ins;
	logic [dataWidth-1:0] regFile [8];
	logic [dataWidth-1:0] rdData1, rdData2, immExt;
	logic [regSelWidth-1:0] dest;
	logic [1:0] aluOp;
	logic aluSrc, memRead, memWrite, regWrite, memToReg, link;
	logic isBeqz, isJump, isHalt, illegal, taken;

	assign ins = instrD;
	assign immExt = {{(dataWidth - 5){ins.i.imm[4]}}, ins.i.imm};

	//**************************************************************************
	// Opcode decode
	//**************************************************************************
	always_comb begin
		rs1 = ins.i.rs;
		rs2 = ins.r.rt;
		uses1 = 1'b0;
		uses2 = 1'b0;
		dest = ins.i.rd;
		aluOp = aluAdd;
		aluSrc = 1'b1;
		{memRead, memWrite, regWrite, memToReg, link} = '0;
		{isBeqz, isJump, isHalt, illegal} = '0;
		case (ins.r.opcode)
			opAdd, opSub, opAnd, opXor: begin
				{uses1, uses2, regWrite} = 3'b111;
				aluSrc = 1'b0;
				dest = ins.r.rd;
				aluOp = ins.r.opcode[1:0];
			end
			opAddi: {uses1, regWrite} = 2'b11;
			opLd: {uses1, regWrite, memRead, memToReg} = 4'b1111;
			opSt: begin
				// Store data comes from the rd field
				rs2 = ins.i.rd;
				{uses1, uses2, memWrite} = 3'b111;
			end
			opBeqz: {uses1, isBeqz} = 2'b11;
			opJ: isJump = 1'b1;
			opJal: begin
				{isJump, link, regWrite} = 3'b111;
				dest = 3'd7;
			end
			opNop: ;
			opHalt: isHalt = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	// Register file, a same-cycle write is seen by the read
	always_ff @(posedge clk) begin
		if (wbEn)
			regFile[wbSel] <= wbData;
	end

	assign rdData1 = (wbEn && wbSel == rs1) ? wbData : regFile[rs1];
	assign rdData2 = (wbEn && wbSel == rs2) ? wbData : regFile[rs2];

	// Control transfer resolves here
	assign taken = isJump || (isBeqz && rdData1 == '0);
	assign flush = taken && !stall;
	assign targetPc = pcPlus2D + {immExt[dataWidth-2:0], 1'b0};
	assign halting = isHalt;

	//**************************************************************************
	// Decode to execute register
	//**************************************************************************
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			{memReadX, memWriteX, regWriteX, memToRegX, linkX} <= '0;
			{haltX, illegalX} <= '0;
		end else begin
			{memReadX, memWriteX, regWriteX} <= {memRead, memWrite, regWrite};
			{memToRegX, linkX} <= {memToReg, link};
			{haltX, illegalX} <= {isHalt, illegal};
		end
		rdData1X <= rdData1;
		rdData2X <= rdData2;
		immX <= immExt;
		aluOpX <= aluOp;
		aluSrcX <= aluSrc;
		destX <= dest;
		pcPlus2X <= pcPlus2D;
	end

endmodule

`default_nettype wire

/* hw/execute.sv */
`default_nettype none

module execute (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [procPkg::dataWidth-1:0]     rdData1X,
	input  logic [procPkg::dataWidth-1:0]     rdData2X,
	input  logic [procPkg::dataWidth-1:0]     immX,
	input  logic [1:0]                        aluOpX,
	input  logic                              aluSrcX,
	input  logic                              memReadX,
	input  logic                              memWriteX,
	input  logic                              regWriteX,
	input  logic                              memToRegX,
	input  logic                              linkX,
	input  logic [procPkg::regSelWidth-1:0]   destX,
	input  logic [procPkg::dataWidth-1:0]     pcPlus2X,
	input  logic                              haltX,
	input  logic                              illegalX,
	output logic [procPkg::dataWidth-1:0]     aluResM,
	output logic [procPkg::dataWidth-1:0]     storeDataM,
	output logic [procPkg::regSelWidth-1:0]   destM,
	output logic                              regWriteM,
	output logic                              memReadM,
	output logic                              memWriteM,
	output logic                              memToRegM,
	output logic                              linkM,
	output logic [procPkg::dataWidth-1:0]     pcPlus2M,
	output logic                              haltM,
	output logic                              illegalM
);
	import procPkg::*;

	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluRes;

	// Second operand is the immediate for I-format
	assign opB = aluSrcX ? immX : rdData2X;

	// Results wrap at the word width
	always_comb begin
		case (aluOpX)
			aluAdd: aluRes = rdData1X + opB;
			aluSub: aluRes = rdData1X - opB;
			aluAnd: aluRes = rdData1X & opB;
			aluXor: aluRes = rdData1X ^ opB;
			default: aluRes = '0;
		endcase
	end

	//**************************************************************************
	// Execute to memory register
	//**************************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			{regWriteM, memReadM, memWriteM, memToRegM} <= '0;
			{linkM, haltM, illegalM} <= '0;
		end else begin
			{regWriteM, memReadM, memWriteM} <= {regWriteX, memReadX, memWriteX};
			memToRegM <= memToRegX;
			{linkM, haltM, illegalM} <= {linkX, haltX, illegalX};
		end
	end

	always_ff @(posedge clk) begin
		aluResM <= aluRes;
		storeDataM <= rdData2X;
		destM <= destX;
		pcPlus2M <= pcPlus2X;
	end

endmodule

`default_nettype wire

/* hw/fetch.sv */
`default_nettype none

module fetch (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            stall,
	input  logic                            flush,
	input  logic [procPkg::dataWidth-1:0]   targetPc,
	input  logic                            halting,
	output logic [procPkg::dataWidth-1:0]   instrD,
	output logic [procPkg::dataWidth-1:0]   pcPlus2D
);
	import procPkg::*;

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] pcPlus2;
	logic [dataWidth-1:0] fetchWord;
	logic [dataWidth-1:0] imem [imemDepth];
	logic advance;

	// Program image
	initial $readmemh("program.hex", imem);

	// Byte PC, word-addressed ROM
	assign fetchWord = imem[pc[imemAddrWidth:1]];
	assign pcPlus2 = pc + dataWidth'(2);
	assign advance = !stall && !halting;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instrD <= nopWord;
		end else if (flush) begin
			// Redirect and squash the wrong-path word
			pc <= targetPc;
			instrD <= nopWord;
		end else if (advance) begin
			pc <= pcPlus2;
			instrD <= fetchWord;
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			pcPlus2D <= pcPlus2;
	end

endmodule

`default_nettype wire

/* hw/hazardDetect.sv */
`default_nettype none

module hazardDetect (
	input  logic [procPkg::regSelWidth-1:0]   rs1,
	input  logic [procPkg::regSelWidth-1:0]   rs2,
	input  logic                              uses1,
	input  logic                              uses2,
	input  logic [procPkg::regSelWidth-1:0]   destX,
	input  logic                              regWriteX,
	input  logic [procPkg::regSelWidth-1:0]   destM,
	input  logic                              regWriteM,
	output logic                              stall
);
	logic hit1;
	logic hit2;

	// Used source still waiting on an older write in execute or memory
	assign hit1 = uses1 && ((regWriteX && destX == rs1) || (regWriteM && destM == rs1));
	assign hit2 = uses2 && ((regWriteX && destX == rs2) || (regWriteM && destM == rs2));
	assign stall = hit1 || hit2;

endmodule

`default_nettype wire

/* hw/memory.sv */
`default_nettype none

module memory (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [procPkg::dataWidth-1:0]     aluResM,
	input  logic [procPkg::dataWidth-1:0]     storeDataM,
	input  logic [procPkg::regSelWidth-1:0]   destM,
	input  logic                              regWriteM,
	input  logic                              memReadM,
	input  logic                              memWriteM,
	input  logic                              memToRegM,
	input  logic                              linkM,
	input  logic [procPkg::dataWidth-1:0]     pcPlus2M,
	input  logic                              haltM,
	input  logic                              illegalM,
	output logic                              wbEn,
	output logic [procPkg::regSelWidth-1:0]   wbSel,
	output logic [procPkg::dataWidth-1:0]     wbData,
	output logic                              wbHalt,
	output logic                              wbIllegal
);
	import procPkg::*;

	logic [dataWidth-1:0] dmem [dmemDepth];
	logic [dmemAddrWidth-1:0] addr;
	logic [dataWidth-1:0] loadData;
	logic [dataWidth-1:0] resultData;

	// Word index from the low address bits
	assign addr = aluResM[dmemAddrWidth-1:0];

	always_ff @(posedge clk) begin
		if (memWriteM)
			dmem[addr] <= storeDataM;
	end

	assign loadData = memReadM ? dmem[addr] : '0;

	// Writeback source select
	assign resultData = linkM ? pcPlus2M : (memToRegM ? loadData : aluResM);

	always_ff @(posedge clk) begin
		if (rst) begin
			wbEn <= 1'b0;
			wbHalt <= 1'b0;
			wbIllegal <= 1'b0;
		end else begin
			wbEn <= regWriteM;
			wbHalt <= haltM;
			wbIllegal <= illegalM;
		end
		wbSel <= destM;
		wbData <= resultData;
	end

endmodule

`default_nettype wire

/* hw/proc.sv */
`default_nettype none

module proc (
	input  logic                              clk,
	input  logic                              rst,
	output logic                              err,
	output logic                              halted,
	output logic                              wbEn,
	output logic [procPkg::regSelWidth-1:0]   wbSel,
	output logic [procPkg::dataWidth-1:0]     wbData
);
	import procPkg::*;

	// Fetch and decode
	logic [dataWidth-1:0] instrD, pcPlus2D, targetPc;
	logic stall, flush, halting;
	logic [regSelWidth-1:0] rs1, rs2;
	logic uses1, uses2;

	// Decode to execute
	logic [dataWidth-1:0] rdData1X, rdData2X, immX, pcPlus2X;
	logic [1:0] aluOpX;
	logic [regSelWidth-1:0] destX;
	logic aluSrcX, memReadX, memWriteX, regWriteX, memToRegX, linkX, haltX, illegalX;

	// Execute to memory
	logic [dataWidth-1:0] aluResM, storeDataM, pcPlus2M;
	logic [regSelWidth-1:0] destM;
	logic regWriteM, memReadM, memWriteM, memToRegM, linkM, haltM, illegalM;

	// Retirement status
	logic wbHalt, wbIllegal;

	//**************************************************************************
	// Pipeline stages
	//**************************************************************************
	fetch fetch0 (.clk, .rst, .stall, .flush, .targetPc, .halting, .instrD, .pcPlus2D);

	hazardDetect hazard0 (.rs1, .rs2, .uses1, .uses2, .destX, .regWriteX, .destM, .regWriteM,
		.stall);

	decode decode0 (.clk, .rst, .instrD, .pcPlus2D, .stall, .wbEn, .wbSel, .wbData,
		.rs1, .rs2, .uses1, .uses2, .flush, .targetPc, .halting,
		.rdData1X, .rdData2X, .immX, .aluOpX, .aluSrcX, .memReadX, .memWriteX,
		.regWriteX, .memToRegX, .linkX, .destX, .pcPlus2X, .haltX, .illegalX);

	execute execute0 (.clk, .rst, .rdData1X, .rdData2X, .immX, .aluOpX, .aluSrcX,
		.memReadX, .memWriteX, .regWriteX, .memToRegX, .linkX, .destX, .pcPlus2X,
		.haltX, .illegalX, .aluResM, .storeDataM, .destM, .regWriteM, .memReadM,
		.memWriteM, .memToRegM, .linkM, .pcPlus2M, .haltM, .illegalM);

	memory memory0 (.clk, .rst, .aluResM, .storeDataM, .destM, .regWriteM, .memReadM,
		.memWriteM, .memToRegM, .linkM, .pcPlus2M, .haltM, .illegalM,
		.wbEn, .wbSel, .wbData, .wbHalt, .wbIllegal);

	// Sticky status, cleared only by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			if (wbHalt)
				halted <= 1'b1;
			if (wbIllegal)
				err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/procPkg.sv */
`default_nettype none

package procPkg;

	//**************************************************************************
	// Machine sizes
	//**************************************************************************
	localparam int dataWidth = 16;
	localparam int regSelWidth = 3;
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int imemAddrWidth = $clog2(imemDepth);
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	//**************************************************************************
	// Opcodes, top five bits of the instruction
	//**************************************************************************
	localparam logic [4:0] opHalt = 5'b00000;
	localparam logic [4:0] opNop = 5'b00001;
	localparam logic [4:0] opJ = 5'b00100;
	localparam logic [4:0] opJal = 5'b00110;
	localparam logic [4:0] opAddi = 5'b01000;
	localparam logic [4:0] opBeqz = 5'b01100;
	localparam logic [4:0] opSt = 5'b10000;
	localparam logic [4:0] opLd = 5'b10001;
	localparam logic [4:0] opAdd = 5'b11000;
	localparam logic [4:0] opSub = 5'b11001;
	localparam logic [4:0] opAnd = 5'b11010;
	localparam logic [4:0] opXor = 5'b11011;

	// Bubble inserted on flush and held in decode after reset
	localparam logic [dataWidth-1:0] nopWord = {opNop, 11'b0};

	// ALU function select
	localparam logic [1:0] aluAdd = 2'd0;
	localparam logic [1:0] aluSub = 2'd1;
	localparam logic [1:0] aluAnd = 2'd2;
	localparam logic [1:0] aluXor = 2'd3;

	// One instruction word, read as R-format or I-format
	typedef union packed {
		struct packed {
			logic [4:0] opcode;
			logic [2:0] rs;
			logic [2:0] rt;
			logic [2:0] rd;
			logic [1:0] spare;
		} r;
		struct packed {
			logic [4:0] opcode;
			logic [2:0] rs;
			logic [2:0] rd;
			logic [4:0] imm;
		} i;
	} instrWord;

endpackage

`default_nettype wire

/* proc.f */
hw/procPkg.sv
hw/fetch.sv
hw/hazardDetect.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/proc.sv
verification/proc_assert.sv
verification/procTb.sv

/* program.hex */
// One 16-bit instruction word per line, from word address 0
// Fields: opcode[15:11] rs[10:8], then rt rd spare (R) or rd imm5 (I)
d800 // xor  r0, r0, r0
4025 // addi r1, r0, 5      uses r0 right after it is written
405d // addi r2, r0, -3
c14c // add  r3, r1, r2
c830 // sub  r4, r0, r1     wraps below zero
d454 // and  r5, r4, r2
dd38 // xor  r6, r5, r1
8162 // st   r3, 2(r1)
88e7 // ld   r7, 7(r0)      same address as the store
80c3 // st   r6, 3(r0)
895e // ld   r2, -2(r1)
8982 // ld   r4, 2(r1)
c450 // add  r4, r4, r2     load-use
6001 // beqz r0, +1         taken
4121 // addi r1, r1, 1      flushed
6101 // beqz r1, +1         not taken
413f // addi r1, r1, -1
2001 // j    +1
4361 // addi r3, r3, 1      flushed
3002 // jal  +2
45a1 // addi r5, r5, 1      flushed
46c1 // addi r6, r6, 1      jumped over
c704 // add  r1, r7, r0     reads the link value
c9f4 // sub  r5, r1, r7
6501 // beqz r5, +1         taken, depends on the sub
4241 // addi r2, r2, 1      flushed
f8e5 // illegal opcode
0800 // nop
0000 // halt
4121 // addi r1, r1, 1      after halt, never retires

/* verification/procTb.sv */
`default_nettype none

module procTb;
	timeunit 1ns;
	timeprecision 100ps;
	import procPkg::*;

	logic clk;
	logic rst;
	logic err;
	logic halted;
	logic wbEn;
	logic [regSelWidth-1:0] wbSel;
	logic [dataWidth-1:0] wbData;

	// Program image and expected retirement stream
	logic [dataWidth-1:0] progMem [imemDepth];
	logic [regSelWidth-1:0] expSel [$];
	logic [dataWidth-1:0] expData [$];
	logic modelHalts;
	logic modelIllegal;
	int errors;
	int writes;
	int cycles;

	proc proc_i (.clk, .rst, .err, .halted, .wbEn, .wbSel, .wbData);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	//**************************************************************************
	// ISA model, one instruction per step, no pipeline
	//**************************************************************************
	function automatic void runModel();
		logic [dataWidth-1:0] regs [8];
		logic [dataWidth-1:0] dmem [dmemDepth];
		logic [dataWidth-1:0] pc, next, imm, a, b, val, sum;
		logic [regSelWidth-1:0] sel;
		logic wr;
		logic running;
		int steps;
		instrWord ins;
		foreach (regs[k])
			regs[k] = '0;
		pc = '0;
		running = 1'b1;
		steps = 0;
		modelHalts = 1'b0;
		modelIllegal = 1'b0;
		while (running && steps < 2000) begin
			ins = progMem[pc[imemAddrWidth:1]];
			imm = {{(dataWidth - 5){ins.i.imm[4]}}, ins.i.imm};
			a = regs[ins.i.rs];
			sum = a + imm;
			next = pc + 16'd2;
			wr = 1'b0;
			sel = ins.i.rd;
			val = '0;
			case (ins.r.opcode)
				opAdd, opSub, opAnd, opXor: begin
					wr = 1'b1;
					sel = ins.r.rd;
					b = regs[ins.r.rt];
					if (ins.r.opcode == opAdd)
						val = a + b;
					else if (ins.r.opcode == opSub)
						val = a - b;
					else if (ins.r.opcode == opAnd)
						val = a & b;
					else
						val = a ^ b;
				end
				opAddi: begin
					wr = 1'b1;
					val = sum;
				end
				opLd: begin
					wr = 1'b1;
					val = dmem[sum[dmemAddrWidth-1:0]];
				end
				opSt: dmem[sum[dmemAddrWidth-1:0]] = regs[ins.i.rd];
				opBeqz: begin
					if (a == '0)
						next = pc + 16'd2 + (imm << 1);
				end
				opJ: next = pc + 16'd2 + (imm << 1);
				opJal: begin
					// Link register is r7
					wr = 1'b1;
					sel = 3'd7;
					val = pc + 16'd2;
					next = pc + 16'd2 + (imm << 1);
				end
				opNop: ;
				opHalt: begin
					modelHalts = 1'b1;
					running = 1'b0;
				end
				default: modelIllegal = 1'b1;
			endcase
			if (wr) begin
				regs[sel] = val;
				expSel.push_back(sel);
				expData.push_back(val);
			end
			pc = next;
			steps++;
		end
	endfunction

	// Retirement compare, sampled away from the rising edge
	always @(negedge clk) begin
		if (!rst && wbEn) begin
			if (halted) begin
				$display("register write retired after halted was set");
				errors++;
			end
			if (writes < expSel.size()) begin
				checkValue("wbSel", wbSel, expSel[writes]);
				checkValue("wbData", wbData, expData[writes]);
			end else begin
				$display("register write beyond the expected number of writes");
				errors++;
			end
			writes++;
		end
	end

	initial begin
		errors = 0;
		writes = 0;
		cycles = 0;
		rst = 1'b1;
		$readmemh("program.hex", progMem);
		runModel();
		repeat (4) @(negedge clk);
		rst = 1'b0;

		while (!halted && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: halted did not rise within 2000 cycles");
			errors++;
		end

		// Quiet window, no write may follow the halt
		repeat (10) @(negedge clk);
		checkValue("halted", halted, modelHalts);
		checkValue("err", err, modelIllegal);
		checkValue("writeCount", writes, expSel.size());

		$display("errors: %0d, register writes: %0d of %0d expected", errors, writes,
			expSel.size());
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/proc_assert.sv */
`default_nettype none

module procAssert (
	input logic clk,
	input logic rst,
	input logic wbEn,
	input logic halted,
	input logic err,
	input logic stall,
	input logic [procPkg::dataWidth-1:0] instrD
);
	timeunit 1ns;
	timeprecision 100ps;

	// Status outputs are clear one cycle after reset
	assert property (@(posedge clk) rst |=> !wbEn && !halted && !err)
		else $error("status outputs not clear after reset");

	// A stalled instruction stays in decode
	assert property (@(posedge clk) disable iff (rst) stall |=> $stable(instrD))
		else $error("fetch to decode register changed during a stall");

	assert property (@(posedge clk) disable iff (rst) halted |-> !wbEn)
		else $error("register write after halt");

endmodule

bind proc procAssert procAssert_i (.clk, .rst, .wbEn, .halted, .err, .stall, .instrD);

`default_nettype wire
